/* hw/core_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// hart definitions
// operation encoding and accumulator reset value of the small harts
////////////////////////////////////////////////////////////////////////////

package core_pkg;

  // hart operations, one per strobe
  typedef enum logic [1:0] {
    OP_NOP  = 2'd0, // keep the result
    OP_ADD  = 2'd1, // result + operand
    OP_XOR  = 2'd2, // result ^ operand
    OP_LOAD = 2'd3  // result = operand
  } core_op_e;

  // accumulator value after reset
  // cast to DataWidth where it is used
  localparam int unsigned ACC_RESET_VALUE = 0;

endpackage : core_pkg

/* hw/hmr_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// hmr register map
// byte addresses, bit positions and the error read value of the
// redundancy unit register slave
////////////////////////////////////////////////////////////////////////////

package hmr_pkg;

  // 4-bit byte address on the register bus
  typedef logic [3:0] reg_addr_t;

  // register addresses
  localparam reg_addr_t REG_CTRL       = 4'h0; // lockstep enable
  localparam reg_addr_t REG_STATUS     = 4'h4; // mismatch count and sticky fault
  localparam reg_addr_t REG_CHECKPOINT = 4'h8; // read only

  // REG_CTRL fields
  localparam int unsigned CTRL_LOCKSTEP_BIT = 0;

  // REG_STATUS fields
  // count sits in the low bits, the fault flag right above it
  localparam int unsigned STATUS_COUNT_WIDTH = 16;
  localparam int unsigned STATUS_FAULT_BIT   = 16;

  // read data for an unmapped address
  localparam logic [31:0] REG_ERR_VALUE = 32'hBADC0DE5;

endpackage : hmr_pkg

/* hw/mini_core.sv */
////////////////////////////////////////////////////////////////////////////
// mini_core
// accumulator hart, one operation per strobe, one cycle latency,
// checkpoint reload on restore and a bit-flip hook for fault testing
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module mini_core import core_pkg::*; #(
  parameter int unsigned DataWidth = 32
) (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  input  logic                 op_valid_i,
  input  core_op_e             op_i,
  input  logic [DataWidth-1:0] operand_i,
  input  logic                 restore_i,
  input  logic [DataWidth-1:0] restore_value_i,
  input  logic                 seu_inject_i,
  output logic [DataWidth-1:0] res_o,
  output logic                 res_valid_o
);

  logic [DataWidth-1:0] acc_d, acc_q;
  logic                 valid_q;

  // next accumulator value
  always_comb begin
    acc_d = acc_q;
    if (restore_i) begin
      acc_d = restore_value_i; // restore wins over a pending op
    end else if (op_valid_i) begin
      case (op_i)
        OP_ADD:  acc_d = acc_q + operand_i;
        OP_XOR:  acc_d = acc_q ^ operand_i;
        OP_LOAD: acc_d = operand_i;
        default: acc_d = acc_q;
      endcase
    end
    // upset model, single bit flip
    if (seu_inject_i) begin
      acc_d[0] = ~acc_d[0];
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      acc_q   <= DataWidth'(ACC_RESET_VALUE);
      valid_q <= 1'b0;
    end else begin
      acc_q   <= acc_d;
      valid_q <= op_valid_i & ~restore_i; // dropped op gives no result
    end
  end

  assign res_o       = acc_q;
  assign res_valid_o = valid_q;

  // a result is only ever flagged right after an accepted strobe
  a_valid_after_op: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    res_valid_o |-> $past(op_valid_i)
  ) else $error("mini_core: res_valid_o without a preceding op_valid_i");

endmodule : mini_core

/* hw/lockstep_unit.sv */
////////////////////////////////////////////////////////////////////////////
// lockstep_unit
// routes system ops to the harts (split or lockstep fan-out), compares
// paired results, keeps the last agreed checkpoint and drives restore
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module lockstep_unit import core_pkg::*; #(
  parameter int unsigned DataWidth = 32
) (
  input  logic                       clk_i,
  input  logic                       arst_n_i,
  input  logic                       lockstep_en_i,
  // system side
  input  logic [1:0]                 sys_op_valid_i,
  input  core_op_e [1:0]             sys_op_i,
  input  logic [1:0][DataWidth-1:0]  sys_operand_i,
  output logic [1:0][DataWidth-1:0]  sys_res_o,
  output logic [1:0]                 sys_res_valid_o,
  // core side
  output logic [1:0]                 core_op_valid_o,
  output core_op_e [1:0]             core_op_o,
  output logic [1:0][DataWidth-1:0]  core_operand_o,
  input  logic [1:0][DataWidth-1:0]  core_res_i,
  input  logic [1:0]                 core_res_valid_i,
  // recovery
  output logic                       restore_o,
  output logic [DataWidth-1:0]       checkpoint_o,
  output logic                       mismatch_o
);

  logic                 lockstep_q;
  logic                 mismatch_q;
  logic                 resync_q;
  logic [DataWidth-1:0] ckpt_q;
  logic                 lockstep_rise;
  logic                 compare_en;
  logic                 results_differ;

  // core 0 always sees hart 0, core 1 follows hart 0 in lockstep
  assign core_op_valid_o[0] = sys_op_valid_i[0];
  assign core_op_o[0]       = sys_op_i[0];
  assign core_operand_o[0]  = sys_operand_i[0];
  assign core_op_valid_o[1] = lockstep_en_i ? sys_op_valid_i[0] : sys_op_valid_i[1];
  assign core_op_o[1]       = lockstep_en_i ? sys_op_i[0]       : sys_op_i[1];
  assign core_operand_o[1]  = lockstep_en_i ? sys_operand_i[0]  : sys_operand_i[1];

  // hart 1 mirrors core 0 while locked
  assign sys_res_o[0]       = core_res_i[0];
  assign sys_res_valid_o[0] = core_res_valid_i[0];
  assign sys_res_o[1]       = lockstep_en_i ? core_res_i[0] : core_res_i[1];
  assign sys_res_valid_o[1] = lockstep_en_i ? core_res_valid_i[0] : core_res_valid_i[1];

  assign lockstep_rise  = lockstep_en_i & ~lockstep_q;
  assign results_differ = core_res_i[0] != core_res_i[1];

  // compare only in settled lockstep and never while a restore is out
  assign compare_en = lockstep_en_i & lockstep_q & (&core_res_valid_i) & ~restore_o;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      lockstep_q <= 1'b0;
      mismatch_q <= 1'b0;
      resync_q   <= 1'b0;
      ckpt_q     <= DataWidth'(ACC_RESET_VALUE);
    end else begin
      lockstep_q <= lockstep_en_i;
      mismatch_q <= compare_en & results_differ;
      resync_q   <= lockstep_rise; // pull core 1 onto core 0 on entry
      if (lockstep_rise || (compare_en && !results_differ)) begin
        ckpt_q <= core_res_i[0];
      end
    end
  end

  assign mismatch_o   = mismatch_q;
  assign restore_o    = mismatch_q | resync_q;
  assign checkpoint_o = ckpt_q;

  a_restore_single: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    restore_o |=> !restore_o
  ) else $error("lockstep_unit: restore_o high for two cycles");

  // a mismatch needs a paired compare in lockstep one cycle earlier
  a_mismatch_locked: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    mismatch_o |-> $past(lockstep_en_i && (&core_res_valid_i))
  ) else $error("lockstep_unit: mismatch_o outside a lockstep compare");

endmodule : lockstep_unit

/* hw/hmr_regs.sv */
////////////////////////////////////////////////////////////////////////////
// hmr_regs
// register slave with lockstep control, saturating mismatch counter,
// sticky fault flag and checkpoint readback
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module hmr_regs import hmr_pkg::*; #(
  parameter int unsigned DataWidth = 32
) (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  input  logic                 reg_valid_i,
  input  logic                 reg_write_i,
  input  reg_addr_t            reg_addr_i,
  input  logic [31:0]          reg_wdata_i,
  output logic [31:0]          reg_rdata_o,
  output logic                 reg_error_o,
  input  logic                 mismatch_i,
  input  logic [DataWidth-1:0] checkpoint_i,
  output logic                 lockstep_en_o
);

  logic                          lockstep_q;
  logic [STATUS_COUNT_WIDTH-1:0] count_q;
  logic                          fault_q;
  logic                          addr_hit;
  logic                          wr_ctrl;
  logic                          wr_status;

  assign wr_ctrl   = reg_valid_i & reg_write_i & (reg_addr_i == REG_CTRL);
  assign wr_status = reg_valid_i & reg_write_i & (reg_addr_i == REG_STATUS);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      lockstep_q <= 1'b0;
      count_q    <= '0;
      fault_q    <= 1'b0;
    end else begin
      if (wr_ctrl) begin
        lockstep_q <= reg_wdata_i[CTRL_LOCKSTEP_BIT];
      end
      if (wr_status) begin
        // clear, but keep a mismatch landing on the same edge
        count_q <= STATUS_COUNT_WIDTH'(mismatch_i);
        fault_q <= mismatch_i;
      end else if (mismatch_i) begin
        fault_q <= 1'b1;
        if (count_q != '1) count_q <= count_q + 1'b1; // saturate
      end
    end
  end

  // read mux, same cycle as reg_valid_i
  always_comb begin
    reg_rdata_o = '0;
    addr_hit    = 1'b1;
    case (reg_addr_i)
      REG_CTRL:       reg_rdata_o[CTRL_LOCKSTEP_BIT] = lockstep_q;
      REG_STATUS: begin
        reg_rdata_o[STATUS_COUNT_WIDTH-1:0] = count_q;
        reg_rdata_o[STATUS_FAULT_BIT]       = fault_q;
      end
      REG_CHECKPOINT: reg_rdata_o = 32'(checkpoint_i); // zero-extended
      default: begin
        reg_rdata_o = REG_ERR_VALUE;
        addr_hit    = 1'b0;
      end
    endcase
  end

  // checkpoint is read only
  assign reg_error_o = reg_valid_i &
                       (~addr_hit | (reg_write_i & (reg_addr_i == REG_CHECKPOINT)));

  assign lockstep_en_o = lockstep_q;

  a_error_needs_valid: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    reg_error_o |-> reg_valid_i
  ) else $error("hmr_regs: reg_error_o without reg_valid_i");

endmodule : hmr_regs

/* hw/dmr_core_pair.sv */
////////////////////////////////////////////////////////////////////////////
// dmr_core_pair
// two accumulator harts behind a lockstep unit, configured over a
// small register bus
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module dmr_core_pair import core_pkg::*, hmr_pkg::*; #(
  parameter int unsigned DataWidth = 32
) (
  input  logic                      clk_i,
  input  logic                      arst_n_i,
  // per hart system ports
  input  logic [1:0]                op_valid_i,
  input  core_op_e [1:0]            op_i,
  input  logic [1:0][DataWidth-1:0] operand_i,
  input  logic [1:0]                seu_inject_i,
  output logic [1:0][DataWidth-1:0] res_o,
  output logic [1:0]                res_valid_o,
  // register bus
  input  logic                      reg_valid_i,
  input  logic                      reg_write_i,
  input  reg_addr_t                 reg_addr_i,
  input  logic [31:0]               reg_wdata_i,
  output logic [31:0]               reg_rdata_o,
  output logic                      reg_error_o,
  output logic                      dmr_error_o
);

  logic [1:0]                core_op_valid;
  core_op_e [1:0]            core_op;
  logic [1:0][DataWidth-1:0] core_operand;
  logic [1:0][DataWidth-1:0] core_res;
  logic [1:0]                core_res_valid;
  logic                      restore;
  logic [DataWidth-1:0]      checkpoint;
  logic                      mismatch;
  logic                      lockstep_en;

  mini_core #(
    .DataWidth ( DataWidth )
  ) u_core0 (
    .clk_i           ( clk_i             ),
    .arst_n_i        ( arst_n_i          ),
    .op_valid_i      ( core_op_valid[0]  ),
    .op_i            ( core_op[0]        ),
    .operand_i       ( core_operand[0]   ),
    .restore_i       ( restore           ),
    .restore_value_i ( checkpoint        ),
    .seu_inject_i    ( seu_inject_i[0]   ), // never routed by mode
    .res_o           ( core_res[0]       ),
    .res_valid_o     ( core_res_valid[0] )
  );

  mini_core #(
    .DataWidth ( DataWidth )
  ) u_core1 (
    .clk_i           ( clk_i             ),
    .arst_n_i        ( arst_n_i          ),
    .op_valid_i      ( core_op_valid[1]  ),
    .op_i            ( core_op[1]        ),
    .operand_i       ( core_operand[1]   ),
    .restore_i       ( restore           ),
    .restore_value_i ( checkpoint        ),
    .seu_inject_i    ( seu_inject_i[1]   ),
    .res_o           ( core_res[1]       ),
    .res_valid_o     ( core_res_valid[1] )
  );

  lockstep_unit #(
    .DataWidth ( DataWidth )
  ) u_lockstep (
    .clk_i            ( clk_i          ),
    .arst_n_i         ( arst_n_i       ),
    .lockstep_en_i    ( lockstep_en    ),
    .sys_op_valid_i   ( op_valid_i     ),
    .sys_op_i         ( op_i           ),
    .sys_operand_i    ( operand_i      ),
    .sys_res_o        ( res_o          ),
    .sys_res_valid_o  ( res_valid_o    ),
    .core_op_valid_o  ( core_op_valid  ),
    .core_op_o        ( core_op        ),
    .core_operand_o   ( core_operand   ),
    .core_res_i       ( core_res       ),
    .core_res_valid_i ( core_res_valid ),
    .restore_o        ( restore        ),
    .checkpoint_o     ( checkpoint     ),
    .mismatch_o       ( mismatch       )
  );

  hmr_regs #(
    .DataWidth ( DataWidth )
  ) u_regs (
    .clk_i         ( clk_i       ),
    .arst_n_i      ( arst_n_i    ),
    .reg_valid_i   ( reg_valid_i ),
    .reg_write_i   ( reg_write_i ),
    .reg_addr_i    ( reg_addr_i  ),
    .reg_wdata_i   ( reg_wdata_i ),
    .reg_rdata_o   ( reg_rdata_o ),
    .reg_error_o   ( reg_error_o ),
    .mismatch_i    ( mismatch    ),
    .checkpoint_i  ( checkpoint  ),
    .lockstep_en_o ( lockstep_en )
  );

  assign dmr_error_o = mismatch; // one pulse per detected mismatch

endmodule : dmr_core_pair

/* tests/tb_dmr_core_pair.sv */
////////////////////////////////////////////////////////////////////////////
// dmr_core_pair testbench
// drives both harts and the register bus, keeps a reference model of the
// accumulators, checkpoint and counters, and checks the DUT with assertions
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module tb_dmr_core_pair import core_pkg::*, hmr_pkg::*; ();

  localparam int unsigned DataWidth     = 32;
  localparam int unsigned NumTests      = 6;
  localparam int unsigned ResetCycles   = 8;
  localparam int unsigned CyclesPerTest = 200;
  localparam int unsigned ClkPeriodNs   = 20;
  localparam int unsigned WatchdogNs    = (NumTests * CyclesPerTest + ResetCycles) * ClkPeriodNs;

  logic                      clk_i = 1'b0;
  logic                      arst_n_i;
  logic [1:0]                op_valid_i;
  core_op_e [1:0]            op_i;
  logic [1:0][DataWidth-1:0] operand_i;
  logic [1:0]                seu_inject_i;
  logic [1:0][DataWidth-1:0] res_o;
  logic [1:0]                res_valid_o;
  logic                      reg_valid_i;
  logic                      reg_write_i;
  reg_addr_t                 reg_addr_i;
  logic [31:0]               reg_wdata_i;
  logic [31:0]               reg_rdata_o;
  logic                      reg_error_o;
  logic                      dmr_error_o;

  // reference model state
  logic [1:0][DataWidth-1:0] acc_m;
  logic [DataWidth-1:0]      ckpt_m;
  logic [1:0]                valid_m;
  logic                      lock_m;
  logic                      lock_d;
  logic                      bad_m;   // core 1 silently off the shared value
  logic                      err_m;
  logic                      rst_m;
  logic [15:0]               count_m;
  logic                      fault_m;

  // expected outputs
  logic [1:0][DataWidth-1:0] exp_res;
  logic [1:0]                exp_valid;
  logic [31:0]               exp_rdata;
  logic                      exp_error;

  int err_count  = 0;
  int tests_done = 0;

  dmr_core_pair #(
    .DataWidth ( DataWidth )
  ) dut (
    .clk_i        ( clk_i        ),
    .arst_n_i     ( arst_n_i     ),
    .op_valid_i   ( op_valid_i   ),
    .op_i         ( op_i         ),
    .operand_i    ( operand_i    ),
    .seu_inject_i ( seu_inject_i ),
    .res_o        ( res_o        ),
    .res_valid_o  ( res_valid_o  ),
    .reg_valid_i  ( reg_valid_i  ),
    .reg_write_i  ( reg_write_i  ),
    .reg_addr_i   ( reg_addr_i   ),
    .reg_wdata_i  ( reg_wdata_i  ),
    .reg_rdata_o  ( reg_rdata_o  ),
    .reg_error_o  ( reg_error_o  ),
    .dmr_error_o  ( dmr_error_o  )
  );

  always #(ClkPeriodNs / 2) clk_i = ~clk_i;

  function automatic logic [DataWidth-1:0] apply_op(input logic [DataWidth-1:0] acc,
                                                    input core_op_e op,
                                                    input logic [DataWidth-1:0] val);
    case (op)
      OP_ADD:  return acc + val;
      OP_XOR:  return acc ^ val;
      OP_LOAD: return val;
      default: return acc;
    endcase
  endfunction

  function automatic core_op_e random_op();
    case ($urandom % 3)
      0:       return OP_ADD;
      1:       return OP_XOR;
      default: return OP_LOAD;
    endcase
  endfunction

  always @(posedge clk_i or negedge arst_n_i) begin
    logic rise;
    logic compare;
    if (!arst_n_i) begin
      acc_m   <= '0;
      ckpt_m  <= '0;
      valid_m <= '0;
      lock_m  <= 1'b0;
      lock_d  <= 1'b0;
      bad_m   <= 1'b0;
      err_m   <= 1'b0;
      rst_m   <= 1'b0;
      count_m <= '0;
      fault_m <= 1'b0;
    end else begin
      rise    = lock_m & ~lock_d;
      compare = lock_m & lock_d & valid_m[0] & ~rst_m;
      lock_d <= lock_m;
      if (reg_valid_i && reg_write_i && reg_addr_i == REG_CTRL) begin
        lock_m <= reg_wdata_i[CTRL_LOCKSTEP_BIT];
      end
      err_m <= compare & bad_m;
      rst_m <= (compare & bad_m) | rise; // mismatch or lockstep entry
      if (rise || (compare && !bad_m)) begin
        ckpt_m <= acc_m[0];
      end
      if (rst_m) begin
        acc_m[0] <= ckpt_m;
        acc_m[1] <= ckpt_m;
        valid_m  <= '0;
        bad_m    <= 1'b0;
      end else if (lock_m) begin
        valid_m <= {2{op_valid_i[0]}}; // hart 0 drives both
        if (op_valid_i[0]) begin
          acc_m[0] <= apply_op(acc_m[0], op_i[0], operand_i[0]);
          acc_m[1] <= apply_op(acc_m[0], op_i[0], operand_i[0]);
        end
        if (seu_inject_i[1]) bad_m <= 1'b1;
      end else begin
        for (int i = 0; i < 2; i++) begin
          valid_m[i] <= op_valid_i[i];
          acc_m[i]   <= (op_valid_i[i] ? apply_op(acc_m[i], op_i[i], operand_i[i]) : acc_m[i])
                        ^ DataWidth'(seu_inject_i[i]);
        end
      end
      if (reg_valid_i && reg_write_i && reg_addr_i == REG_STATUS) begin
        count_m <= {15'd0, err_m};
        fault_m <= err_m;
      end else if (err_m) begin
        fault_m <= 1'b1;
        if (count_m != 16'hFFFF) count_m <= count_m + 16'd1;
      end
    end
  end

  always_comb begin
    exp_res[0]   = acc_m[0];
    exp_res[1]   = lock_m ? acc_m[0] : acc_m[1];
    exp_valid[0] = valid_m[0];
    exp_valid[1] = lock_m ? valid_m[0] : valid_m[1];
    exp_error    = 1'b0;
    case (reg_addr_i)
      REG_CTRL:   exp_rdata = {31'd0, lock_m};
      REG_STATUS: exp_rdata = {15'd0, fault_m, count_m};
      REG_CHECKPOINT: begin
        exp_rdata = ckpt_m;
        exp_error = reg_write_i; // read only
      end
      default: begin
        exp_rdata = REG_ERR_VALUE;
        exp_error = 1'b1;        // nothing mapped here
      end
    endcase
  end

  a_res0: assert property (@(posedge clk_i) disable iff (!arst_n_i) res_o[0] == exp_res[0])
    else begin
      err_count++;
      $display("CHECK FAILED t=%0t hart 0 result %h, expected %h",
               $time, $sampled(res_o[0]), $sampled(exp_res[0]));
    end
  a_res1: assert property (@(posedge clk_i) disable iff (!arst_n_i) res_o[1] == exp_res[1])
    else begin
      err_count++;
      $display("CHECK FAILED t=%0t hart 1 result %h, expected %h",
               $time, $sampled(res_o[1]), $sampled(exp_res[1]));
    end
  a_valid: assert property (@(posedge clk_i) disable iff (!arst_n_i) res_valid_o == exp_valid)
    else begin
      err_count++;
      $display("CHECK FAILED t=%0t res_valid_o %b, expected %b",
               $time, $sampled(res_valid_o), $sampled(exp_valid));
    end
  a_dmr_error: assert property (@(posedge clk_i) disable iff (!arst_n_i) dmr_error_o == err_m)
    else begin
      err_count++;
      $display("CHECK FAILED t=%0t dmr_error_o %b, expected %b",
               $time, $sampled(dmr_error_o), $sampled(err_m));
    end
  a_reg_error: assert property (@(posedge clk_i) disable iff (!arst_n_i)
                                reg_error_o == (reg_valid_i && exp_error))
    else begin
      err_count++;
      $display("CHECK FAILED t=%0t reg_error_o %b, expected %b",
               $time, $sampled(reg_error_o), $sampled(reg_valid_i && exp_error));
    end
  a_rdata: assert property (@(posedge clk_i) disable iff (!arst_n_i)
                            reg_valid_i |-> reg_rdata_o == exp_rdata)
    else begin
      err_count++;
      $display("CHECK FAILED t=%0t read of 0x%h gave %h, expected %h", $time,
               $sampled(reg_addr_i), $sampled(reg_rdata_o), $sampled(exp_rdata));
    end

  // inputs change 2 ns after the rising edge
  task automatic next_slot();
    @(posedge clk_i);
    #2;
  endtask

  task automatic idle(input int unsigned n);
    repeat (n) next_slot();
  endtask

  task automatic issue_ops(input logic [1:0] harts, input logic [1:0] inject);
    next_slot();
    for (int i = 0; i < 2; i++) begin
      op_valid_i[i] = harts[i];
      op_i[i]       = random_op();
      operand_i[i]  = $urandom();
    end
    seu_inject_i = inject;
    next_slot();
    op_valid_i   = '0;
    seu_inject_i = '0;
  endtask

  task automatic write_reg(input reg_addr_t addr, input logic [31:0] data);
    next_slot();
    reg_valid_i = 1'b1;
    reg_write_i = 1'b1;
    reg_addr_i  = addr;
    reg_wdata_i = data;
    next_slot();
    reg_valid_i = 1'b0;
    reg_write_i = 1'b0;
  endtask

  task automatic read_reg(input reg_addr_t addr);
    next_slot();
    reg_valid_i = 1'b1;
    reg_write_i = 1'b0;
    reg_addr_i  = addr;
    reg_wdata_i = '0;
    next_slot();
    reg_valid_i = 1'b0;
  endtask

  task automatic report_test(input string name);
    tests_done++;
    $display("test %0d (%s) done, failed checks so far %0d", tests_done, name, err_count);
  endtask

  initial begin
    #(WatchdogNs);
    $display("timeout: the tests did not finish within %0d ns", WatchdogNs);
    $display("*** FAILED ***");
    $finish;
  end

  initial begin
    void'($urandom(24));
    arst_n_i     = 1'b0;
    op_valid_i   = '0;
    op_i[0]      = OP_NOP;
    op_i[1]      = OP_NOP;
    operand_i    = '0;
    seu_inject_i = '0;
    reg_valid_i  = 1'b0;
    reg_write_i  = 1'b0;
    reg_addr_i   = '0;
    reg_wdata_i  = '0;
    repeat (ResetCycles) @(posedge clk_i);
    #2 arst_n_i = 1'b1;

    idle(2);
    read_reg(REG_CTRL);
    read_reg(REG_STATUS);
    report_test("reset state");

    repeat (20) issue_ops(2'b11, 2'b00);
    issue_ops(2'b00, 2'b10); // upset on hart 1 only
    idle(3);
    repeat (4) issue_ops(2'b11, 2'b00);
    read_reg(REG_STATUS);
    report_test("split mode");

    write_reg(REG_CTRL, 32'h1);
    idle(3);
    repeat (20) issue_ops(2'b11, 2'b00); // hart 1 stream must be ignored
    read_reg(REG_CHECKPOINT);
    report_test("lockstep mode");

    issue_ops(2'b01, 2'b10); // core 1 hit together with a result
    idle(3);
    read_reg(REG_STATUS);
    read_reg(REG_CHECKPOINT);
    repeat (10) issue_ops(2'b11, 2'b00);
    report_test("fault recovery");

    write_reg(REG_STATUS, 32'h0);
    read_reg(REG_STATUS);
    read_reg(4'hC);
    write_reg(REG_CHECKPOINT, $urandom());
    read_reg(REG_CHECKPOINT);
    report_test("register bus");

    write_reg(REG_CTRL, 32'h0);
    idle(2);
    repeat (8) issue_ops(2'b11, 2'b00);
    write_reg(REG_CTRL, 32'h1);
    idle(3);
    read_reg(REG_STATUS);
    read_reg(REG_CHECKPOINT);
    repeat (8) issue_ops(2'b11, 2'b00);
    read_reg(REG_STATUS);
    report_test("re-entry resync");

    $display("tests run %0d, failed checks %0d", tests_done, err_count);
    if (err_count == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule : tb_dmr_core_pair

/* filelist.f */
hw/core_pkg.sv
hw/hmr_pkg.sv
hw/mini_core.sv
hw/lockstep_unit.sv
hw/hmr_regs.sv
hw/dmr_core_pair.sv
tests/tb_dmr_core_pair.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_dmr_core_pair
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
PASS_MSG  := *** PASSED ***

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(BUILD_DIR)
